// ==== verilog/ppfifo_cfg.svh ====
// ============================================================
// Widths shared by every ping-pong FIFO file
// Bank depth is 2**PPFIFO_ADDRESS_WIDTH words
// ============================================================
`ifndef PPFIFO_CFG_SVH
`define PPFIFO_CFG_SVH

// Bits per data word
`define PPFIFO_DATA_WIDTH 8

// Word address bits inside one bank
// 4 bits gives 16 words per bank
`define PPFIFO_ADDRESS_WIDTH 4

`endif

// ==== verilog/ppfifo_pkg.sv ====
// ============================================================
// Types shared by the ping-pong FIFO, sized from the cfg header
// ============================================================
`default_nettype none

`include "ppfifo_cfg.svh"

package ppfifo_pkg;

  // One stored word
  typedef logic [`PPFIFO_DATA_WIDTH-1:0] data_t;

  // Word index inside a single bank
  typedef logic [`PPFIFO_ADDRESS_WIDTH-1:0] word_addr_t;

  // Word count per bank, 0 up to the full depth
  typedef logic [`PPFIFO_ADDRESS_WIDTH:0] count_t;

  // One bit per bank
  typedef logic [1:0] bank_mask_t;

  // Reader FSM
  typedef enum logic [1:0] {
    READ_IDLE,
    READ_PRIME,
    READ_OFFERED,
    READ_ACTIVE
  } read_state_t;

endpackage

`default_nettype wire

// ==== verilog/bank_handoff_if.sv ====
// ============================================================
// Filled banks pass to the reader, releases come back
// ============================================================
`timescale 1ns/1ps
`default_nettype none

interface bank_handoff_if;
  import ppfifo_pkg::*;

  // Level per bank, high from hand-off until release
  bank_mask_t filled;

  // Word counts, held steady while the matching filled bit is high
  count_t count0;
  count_t count1;

  // One-cycle pulse when the reader gives a bank back
  bank_mask_t released;

  modport writer (
    output filled,
    output count0,
    output count1,
    input  released
  );

  modport reader (
    input  filled,
    input  count0,
    input  count1,
    output released
  );

endinterface

`default_nettype wire

// ==== verilog/mem_write_if.sv ====
// ============================================================
// Bank RAM write port, one word per cycle with enable high
// ============================================================
`timescale 1ns/1ps
`default_nettype none

interface mem_write_if;
  import ppfifo_pkg::*;

  logic       enable;
  // Bank select bit
  logic       bank;
  word_addr_t address;
  data_t      data;

  modport source (
    output enable,
    output bank,
    output address,
    output data
  );

  modport sink (
    input enable,
    input bank,
    input address,
    input data
  );

endinterface

`default_nettype wire

// ==== verilog/bank_memory.sv ====
// ============================================================
// Two banks in one simple dual-port RAM
// Read data is registered and appears one edge after the address
// ============================================================
`timescale 1ns/1ps
`default_nettype none

`include "ppfifo_cfg.svh"

module bank_memory (
  input  logic                   write_clock,
  mem_write_if.sink              mem,
  input  logic                   read_bank,
  input  ppfifo_pkg::word_addr_t read_address,
  output ppfifo_pkg::data_t      read_data
);
  import ppfifo_pkg::*;

  localparam int BANK_WORDS = 1 << `PPFIFO_ADDRESS_WIDTH;

  // Bank bit is the top address bit
  data_t storage [2 * BANK_WORDS];

  // Write port
  always_ff @(posedge write_clock) begin
    if (mem.enable) begin
      storage[{mem.bank, mem.address}] <= mem.data;
    end
  end

  // Read port
  // Holding the address keeps read_data steady
  always_ff @(posedge write_clock) begin
    read_data <= storage[{read_bank, read_address}];
  end

endmodule

`default_nettype wire

// ==== verilog/write_bank_control.sv ====
// ============================================================
// Producer side; write_activate must be zero or one-hot
// Strobes past the bank depth are dropped
// ============================================================
`timescale 1ns/1ps
`default_nettype none

`include "ppfifo_cfg.svh"

module write_bank_control (
  input  logic                   write_clock,
  input  logic                   reset,
  input  ppfifo_pkg::bank_mask_t write_activate,
  input  logic                   write_strobe,
  input  ppfifo_pkg::data_t      write_data,
  output ppfifo_pkg::bank_mask_t write_ready,
  bank_handoff_if.writer         handoff,
  mem_write_if.source            mem
);
  import ppfifo_pkg::*;

  localparam count_t BANK_DEPTH = count_t'(1 << `PPFIFO_ADDRESS_WIDTH);

  logic       armed;
  logic       claimed;
  logic       last_bank;
  logic       active;
  logic       active_bank;
  bank_mask_t filled_q;
  // Per-bank fill level, also the next write index
  count_t     count_q [2];

  assign active      = |write_activate;
  assign active_bank = write_activate[1];

  // Memory write port, saturating at the bank depth
  assign mem.enable  = active && write_strobe && (count_q[active_bank] != BANK_DEPTH);
  assign mem.bank    = active_bank;
  assign mem.address = word_addr_t'(count_q[active_bank]);
  assign mem.data    = write_data;

  assign handoff.filled = filled_q;
  assign handoff.count0 = count_q[0];
  assign handoff.count1 = count_q[1];

  always_ff @(posedge write_clock) begin
    if (reset) begin
      armed       <= 1'b0;
      claimed     <= 1'b0;
      last_bank   <= 1'b0;
      write_ready <= '0;
      filled_q    <= '0;
      count_q[0]  <= '0;
      count_q[1]  <= '0;
    end else begin
      // Both banks free after reset
      if (!armed) begin
        armed       <= 1'b1;
        write_ready <= 2'b11;
      end
      if (active) begin
        claimed                  <= 1'b1;
        last_bank                <= active_bank;
        write_ready[active_bank] <= 1'b0;
      end else if (claimed) begin
        claimed <= 1'b0;
        // Hand off a bank with data, or give an empty one straight back
        if (count_q[last_bank] != '0) begin
          filled_q[last_bank] <= 1'b1;
        end else begin
          write_ready[last_bank] <= 1'b1;
        end
      end
      if (mem.enable) begin
        count_q[active_bank] <= count_q[active_bank] + count_t'(1);
      end
      // Reader done with a bank
      for (int i = 0; i < 2; i++) begin
        if (handoff.released[i]) begin
          filled_q[i]    <= 1'b0;
          count_q[i]     <= '0;
          write_ready[i] <= 1'b1;
        end
      end
    end
  end

  a_activate_onehot: assert property (@(posedge write_clock) disable iff (reset)
    $onehot0(write_activate))
    else $error("write_activate has more than one bank set");

  // A bank may only be claimed while it is offered as ready
  for (genvar i = 0; i < 2; i++) begin : g_claim_check
    a_claim_ready: assert property (@(posedge write_clock) disable iff (reset)
      $rose(write_activate[i]) |-> write_ready[i])
      else $error("write_activate raised on bank %0d while not ready", i);
  end

endmodule

`default_nettype wire

// ==== verilog/read_bank_control.sv ====
// ============================================================
// Consumer side serves one bank at a time in hand-off order
// read_data shows the current word before each strobe
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module read_bank_control (
  input  logic                   write_clock,
  input  logic                   reset,
  input  logic                   read_activate,
  input  logic                   read_strobe,
  output logic                   read_ready,
  output ppfifo_pkg::count_t     read_count,
  bank_handoff_if.reader         handoff,
  output logic                   read_bank,
  output ppfifo_pkg::word_addr_t read_address
);
  import ppfifo_pkg::*;

  read_state_t state;
  // Filled banks already offered once
  bank_mask_t  taken;
  bank_mask_t  available;
  bank_mask_t  released_q;
  logic        older_bank;
  logic        next_bank;
  logic        current_bank;
  count_t      pointer;
  count_t      pointer_next;
  logic        advance;

  // Banks handed off but not yet offered
  assign available = handoff.filled & ~taken;

  // Older one wins when both wait
  assign next_bank = (available == 2'b11) ? older_bank : available[1];

  // Strobes past the count do nothing
  assign advance      = (state == READ_ACTIVE) && read_strobe && (pointer < read_count);
  assign pointer_next = pointer + count_t'(1);

  // Look one word ahead so the RAM output tracks the pointer
  // Last word stays on the bus once the bank is drained
  assign read_bank    = current_bank;
  assign read_address = (advance && (pointer_next != read_count)) ?
                        word_addr_t'(pointer_next) :
                        (pointer == read_count) ? word_addr_t'(read_count - count_t'(1)) :
                        word_addr_t'(pointer);

  assign handoff.released = released_q;

  always_ff @(posedge write_clock) begin
    if (reset) begin
      state        <= READ_IDLE;
      taken        <= '0;
      released_q   <= '0;
      older_bank   <= 1'b0;
      current_bank <= 1'b0;
      pointer      <= '0;
      read_ready   <= 1'b0;
      read_count   <= '0;
    end else begin
      released_q <= '0;
      // A lone waiting bank becomes the oldest
      if (available == 2'b01) begin
        older_bank <= 1'b0;
      end else if (available == 2'b10) begin
        older_bank <= 1'b1;
      end
      // Forget a bank once the writer has taken it back
      for (int i = 0; i < 2; i++) begin
        if (!handoff.filled[i]) begin
          taken[i] <= 1'b0;
        end
      end
      if (advance) begin
        pointer <= pointer_next;
      end
      case (state)
        READ_IDLE: begin
          if (available != '0) begin
            state            <= READ_PRIME;
            current_bank     <= next_bank;
            taken[next_bank] <= 1'b1;
            pointer          <= '0;
            read_count       <= next_bank ? handoff.count1 : handoff.count0;
          end
        end
        // Word 0 address is on the RAM, data lands next edge
        READ_PRIME: begin
          state      <= READ_OFFERED;
          read_ready <= 1'b1;
        end
        READ_OFFERED: begin
          if (read_activate) begin
            read_ready <= 1'b0;
            state      <= READ_ACTIVE;
          end
        end
        READ_ACTIVE: begin
          if (!read_activate) begin
            released_q[current_bank] <= 1'b1;
            state                    <= READ_IDLE;
          end
        end
        default: begin
          state <= READ_IDLE;
        end
      endcase
    end
  end

  // Release names exactly one bank, and only one the writer marked filled
  a_release_valid: assert property (@(posedge write_clock) disable iff (reset)
    (handoff.released != '0) |->
      ($onehot(handoff.released) && ((handoff.released & ~handoff.filled) == '0)))
    else $error("released pulse is two-hot or names a bank that is not filled");

endmodule

`default_nettype wire

// ==== verilog/pingpong_fifo.sv ====
// ============================================================
// Single-clock two-bank ping-pong FIFO
// Each bank holds up to 16 words and is read as one burst
// ============================================================
`timescale 1ns/1ps
`default_nettype none

module pingpong_fifo (
  input  logic                   reset,
  input  logic                   write_clock,

  // Producer
  output ppfifo_pkg::bank_mask_t write_ready,
  input  ppfifo_pkg::bank_mask_t write_activate,
  input  logic                   write_strobe,
  input  ppfifo_pkg::data_t      write_data,

  // Consumer
  output logic                   read_ready,
  input  logic                   read_activate,
  input  logic                   read_strobe,
  output ppfifo_pkg::count_t     read_count,
  output ppfifo_pkg::data_t      read_data
);
  import ppfifo_pkg::*;

  // RAM read port
  logic       read_bank;
  word_addr_t read_address;

  bank_handoff_if handoff ();
  mem_write_if    mem_write ();

  write_bank_control writer (
    .write_clock    (write_clock),
    .reset          (reset),
    .write_activate (write_activate),
    .write_strobe   (write_strobe),
    .write_data     (write_data),
    .write_ready    (write_ready),
    .handoff        (handoff.writer),
    .mem            (mem_write.source)
  );

  read_bank_control reader (
    .write_clock   (write_clock),
    .reset         (reset),
    .read_activate (read_activate),
    .read_strobe   (read_strobe),
    .read_ready    (read_ready),
    .read_count    (read_count),
    .handoff       (handoff.reader),
    .read_bank     (read_bank),
    .read_address  (read_address)
  );

  bank_memory banks (
    .write_clock  (write_clock),
    .mem          (mem_write.sink),
    .read_bank    (read_bank),
    .read_address (read_address),
    .read_data    (read_data)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_pingpong_fifo.sv ====
// ============================================================
// Ping-pong FIFO testbench with a 20 ns clock and negedge inputs
// ============================================================
`timescale 1ns/1ps
`default_nettype none

`include "ppfifo_cfg.svh"

module tb_pingpong_fifo;
  import ppfifo_pkg::*;

  localparam int DEPTH = 1 << `PPFIFO_ADDRESS_WIDTH;
  // Six tests of up to 150 cycles each, doubled, plus reset slack
  localparam int CYCLE_LIMIT = 6 * 150 * 2 + 200;

  logic        reset;
  logic        write_clock;
  bank_mask_t  write_ready;
  bank_mask_t  write_activate;
  logic        write_strobe;
  data_t       write_data;
  logic        read_ready;
  logic        read_activate;
  logic        read_strobe;
  count_t      read_count;
  data_t       read_data;

  int          errors = 0;
  int          passed = 0;
  int          failed = 0;
  int          cycles = 0;
  int          test_start = 0;
  logic [16:0] lfsr = 17'd83618;
  // Accepted words per bank, oldest first
  data_t       model_q [2][$];

  pingpong_fifo UUT (.*);

  initial begin
    write_clock = 1'b0;
    forever #10 write_clock = ~write_clock;
  end

  // Run limit
  always @(posedge write_clock) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Errors found");
      $finish;
    end
  end

  // An offered bank always holds at least one word
  a_offer_count: assert property (@(posedge write_clock) disable iff (reset)
    read_ready |-> (read_count != '0))
    else begin
      errors++;
      $display("Bank offered at %0t with a read_count of zero", $time);
    end

  // x^17 + x^14 + 1
  function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  // One LFSR step per data bit
  task automatic random_word(output data_t w);
    for (int b = 0; b < $bits(data_t); b++) begin
      lfsr = lfsr_next(lfsr);
      w[b] = lfsr[0];
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    assert (actual === expected)
      else begin
        errors++;
        $display("CHECK FAILED at %0t: %s = 0x%0h, expected 0x%0h",
                 $time, name, actual, expected);
      end
  endtask

  task automatic end_test(input string name);
    if (errors == test_start) begin
      passed++;
      $display("PASS %s", name);
    end else begin
      failed++;
      $display("FAIL %s", name);
    end
    test_start = errors;
  endtask

  // Claim a bank, strobe n words, then deactivate
  task automatic write_burst(input int bank, input int n);
    data_t w;
    check_value("write_ready[bank]", write_ready[bank], 1);
    write_activate = bank_mask_t'(1 << bank);
    for (int i = 0; i < n; i++) begin
      random_word(w);
      // Words past the depth are dropped
      if (model_q[bank].size() < DEPTH) model_q[bank].push_back(w);
      write_strobe = 1'b1;
      write_data   = w;
      @(negedge write_clock);
    end
    write_strobe = 1'b0;
    if (n == 0) @(negedge write_clock);
    write_activate = '0;
    @(negedge write_clock);
  endtask

  // Take the next offered bank, drain it plus extra strobes, release
  task automatic read_burst(input int bank, input int extra);
    int n;
    n = model_q[bank].size();
    while (!read_ready) @(negedge write_clock);
    check_value("read_count", read_count, n);
    check_value("read_data", read_data, model_q[bank][0]);
    read_activate = 1'b1;
    @(negedge write_clock);
    for (int i = 0; i < n + extra; i++) begin
      check_value("read_data", read_data, model_q[bank][(i < n) ? i : n - 1]);
      read_strobe = 1'b1;
      @(negedge write_clock);
    end
    read_strobe = 1'b0;
    // Last word stays after the bank is drained
    check_value("read_data", read_data, model_q[bank][n - 1]);
    read_activate = 1'b0;
    // Release pulse, then write_ready one edge later
    repeat (2) @(negedge write_clock);
    check_value("write_ready[bank]", write_ready[bank], 1);
    model_q[bank].delete();
  endtask

  initial begin
    reset          = 1'b1;
    write_activate = '0;
    write_strobe   = 1'b0;
    write_data     = '0;
    read_activate  = 1'b0;
    read_strobe    = 1'b0;
    repeat (5) @(negedge write_clock);
    reset = 1'b0;
    @(negedge write_clock);

    check_value("write_ready", write_ready, 2'b11);
    check_value("read_ready", read_ready, 0);
    end_test("reset state");

    write_burst(0, 7);
    read_burst(0, 0);
    end_test("single burst");

    // Bank 0 must come out before bank 1
    write_burst(0, 5);
    write_burst(1, 9);
    read_burst(0, 0);
    read_burst(1, 0);
    end_test("ping-pong order");

    write_burst(1, 20);
    read_burst(1, 0);
    end_test("overflow");

    write_burst(0, 6);
    read_burst(0, 3);
    end_test("over-read");

    // No words, so no hand-off
    write_burst(1, 0);
    check_value("write_ready[1]", write_ready[1], 1);
    repeat (4) begin
      @(negedge write_clock);
      check_value("read_ready", read_ready, 0);
    end
    end_test("empty activation");

    $display("Tests passed: %0d, failed: %0d, check errors: %0d", passed, failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+verilog
verilog/ppfifo_pkg.sv
verilog/bank_handoff_if.sv
verilog/mem_write_if.sv
verilog/bank_memory.sv
verilog/write_bank_control.sv
verilog/read_bank_control.sv
verilog/pingpong_fifo.sv
testbench/tb_pingpong_fifo.sv
